// File: source/scalerGeometryPkg.sv
/*
 * Scaler geometry definitions
 * Widths and types for upstream and downstream row numbers, column numbers,
 * the shrink factor in 1/64 units and the blend fraction. Also holds the row
 * job that the row mapper hands to the line cache, and the fetch address.
 */
package scalerGeometryPkg;

    // Fractional bits of an upstream coordinate
    localparam int fractionBits = 6;

    localparam int rowIndexBits = 11;
    localparam int columnIndexBits = 11;

    typedef logic [rowIndexBits-1:0] rowIndexT;
    typedef logic [columnIndexBits-1:0] columnIndexT;

    // Shrink factor where 64 means 1.0
    typedef logic [fractionBits:0] scaleT;

    typedef logic [fractionBits-1:0] fractionT;

    // Upstream rows and blend fraction for one downstream row
    typedef struct packed {
        rowIndexT upperRow;
        rowIndexT lowerRow;
        fractionT fraction;
    } rowJobT;

    // Address of one upstream pixel on the fetch handshake
    typedef struct packed {
        rowIndexT row;
        columnIndexT column;
    } fetchAddrT;

endpackage

// File: source/pixelPkg.sv
/*
 * Pixel definitions
 * RGB 5-6-5 pixel types, the blend job passed from the line cache to the
 * blender, and the output beat sent to the downstream client.
 */
package pixelPkg;

    typedef logic [4:0] redT;
    typedef logic [5:0] greenT;
    typedef logic [4:0] blueT;

    // Red in the top bits, blue in the bottom bits
    typedef struct packed {
        redT red;
        greenT green;
        blueT blue;
    } rgbPixelT;

    // Both source pixels of one column and the blend fraction
    typedef struct packed {
        rgbPixelT upperPixel;
        rgbPixelT lowerPixel;
        scalerGeometryPkg::fractionT fraction;
    } blendJobT;

    // One blended pixel tagged with its column
    typedef struct packed {
        scalerGeometryPkg::columnIndexT column;
        rgbPixelT pixel;
    } outBeatT;

endpackage

// File: source/rowMapper.sv
/*
 * Row mapper
 * Accepts a downstream row over the request handshake and maps it to the
 * upper and lower upstream rows and the blend fraction. The job is held
 * until the line cache takes it.
 */
`timescale 1ns/10ps

module rowMapper (
    input  logic scalerClock,
    input  logic reset,
    input  scalerGeometryPkg::scaleT shrinkFactor,
    input  logic rowReq,
    input  scalerGeometryPkg::rowIndexT requestRow,
    output logic rowAck,
    output logic jobValid,
    output scalerGeometryPkg::rowJobT rowJob,
    input  logic jobTaken
);
    import scalerGeometryPkg::*;

    localparam int coordinateBits = rowIndexBits + fractionBits;

    typedef logic [coordinateBits-1:0] coordinateT;

    typedef enum logic [1:0] {
        mapIdle,
        mapMultiply,
        mapSplit,
        mapRelease
    } mapStateT;

    mapStateT state;
    coordinateT scaledRow;
    coordinateT halfStep;
    coordinateT centreShift;
    coordinateT coordinate;
    rowIndexT upperRow;
    fractionT fraction;

    // Sample at the centre of the downstream row, shifted back by half a row when shrinking
    assign scaledRow = coordinateT'(requestRow) * coordinateT'(shrinkFactor);
    assign halfStep = coordinateT'(shrinkFactor >> 1);
    assign centreShift = shrinkFactor[fractionBits] ? coordinateT'(1 << (fractionBits - 1)) : '0;

    assign upperRow = coordinate[coordinateBits-1:fractionBits];
    assign fraction = coordinate[fractionBits-1:0];

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            state <= mapIdle;
            rowAck <= 1'b0;
            jobValid <= 1'b0;
        end else begin
            if (jobTaken) begin
                jobValid <= 1'b0;
            end
            case (state)
                mapIdle: begin
                    // A new request waits until the previous job has left the slot
                    if (rowReq && !jobValid) begin
                        state <= mapMultiply;
                    end
                end
                mapMultiply: begin
                    state <= mapSplit;
                end
                mapSplit: begin
                    jobValid <= 1'b1;
                    rowAck <= 1'b1;
                    state <= mapRelease;
                end
                mapRelease: begin
                    if (!rowReq) begin
                        rowAck <= 1'b0;
                        state <= mapIdle;
                    end
                end
                default: begin
                    state <= mapIdle;
                end
            endcase
        end
    end

    always_ff @(posedge scalerClock) begin
        if (state == mapMultiply) begin
            coordinate <= scaledRow + halfStep - centreShift;
        end
        if (state == mapSplit) begin
            rowJob.upperRow <= upperRow;
            rowJob.lowerRow <= (fraction != '0) ? upperRow + 1'b1 : upperRow;
            rowJob.fraction <= fraction;
        end
    end

    requestRowStable: assert property (
        @(posedge scalerClock) disable iff (reset)
        rowReq && $past(rowReq) |-> $stable(requestRow)
    ) else $error("requestRow changed while rowReq was high");

endmodule

// File: source/lineCache.sv
/*
 * Line cache
 * Two line buffers, each tagged with the upstream row it holds. For every
 * row job the missing rows are fetched one pixel per fetch handshake, then
 * both buffers are read column by column to issue blend jobs. A buffer that
 * still holds a needed row is kept, otherwise the older one is replaced.
 */
`timescale 1ns/10ps

module lineCache #(
    parameter int lineColumns = 16
) (
    input  logic scalerClock,
    input  logic reset,
    input  logic jobValid,
    input  scalerGeometryPkg::rowJobT rowJob,
    output logic jobTaken,
    output logic fetchReq,
    output scalerGeometryPkg::fetchAddrT fetchAddr,
    input  logic fetchAck,
    input  pixelPkg::rgbPixelT fetchPixel,
    input  logic advance,
    output logic blendValid,
    output pixelPkg::blendJobT blendJob
);
    import scalerGeometryPkg::*;
    import pixelPkg::*;

    localparam int columnBits = $clog2(lineColumns);
    localparam logic [columnBits-1:0] lastColumn = columnBits'(lineColumns - 1);

    typedef enum logic [1:0] {
        cacheIdle,
        cacheFetch,
        cacheWaitAck,
        cacheReadout
    } cacheStateT;

    cacheStateT state;
    rowJobT currentJob;

    rgbPixelT lineBuffer [2][lineColumns];
    rowIndexT bufferRow [2];
    logic [1:0] bufferValid;
    logic olderBuffer;

    logic fillBuffer;
    rowIndexT fillRow;
    logic [columnBits-1:0] fetchColumn;
    logic [columnBits-1:0] readColumn;

    logic [1:0] holdsUpper;
    logic [1:0] holdsLower;
    logic upperHeld;
    logic lowerHeld;
    logic victimBuffer;
    logic upperBuffer;
    logic lowerBuffer;
    logic captureStrobe;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            holdsUpper[i] = bufferValid[i] && (bufferRow[i] == currentJob.upperRow);
            holdsLower[i] = bufferValid[i] && (bufferRow[i] == currentJob.lowerRow);
        end
    end

    assign upperHeld = |holdsUpper;
    assign lowerHeld = |holdsLower;

    // The older buffer is replaced unless it holds a row this job still needs
    assign victimBuffer = (holdsUpper[olderBuffer] || holdsLower[olderBuffer]) ?
                          !olderBuffer : olderBuffer;

    // Buffer 1 wins only when it holds the row, so both point at one buffer for fraction zero
    assign upperBuffer = holdsUpper[1];
    assign lowerBuffer = holdsLower[1];

    assign jobTaken = (state == cacheIdle) && jobValid;
    assign captureStrobe = (state == cacheWaitAck) && fetchReq && fetchAck;

    assign fetchAddr.row = fillRow;
    assign fetchAddr.column = columnIndexT'(fetchColumn);

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            state <= cacheIdle;
            fetchReq <= 1'b0;
            bufferValid <= '0;
            bufferRow[0] <= '0;
            bufferRow[1] <= '0;
            olderBuffer <= 1'b0;
            fetchColumn <= '0;
            readColumn <= '0;
        end else begin
            case (state)
                cacheIdle: begin
                    if (jobValid) begin
                        state <= cacheFetch;
                    end
                end
                cacheFetch: begin
                    if (upperHeld && lowerHeld) begin
                        readColumn <= '0;
                        state <= cacheReadout;
                    end else begin
                        // The victim's old contents are lost from the first write on
                        bufferValid[victimBuffer] <= 1'b0;
                        fetchColumn <= '0;
                        fetchReq <= 1'b1;
                        state <= cacheWaitAck;
                    end
                end
                cacheWaitAck: begin
                    if (fetchReq && fetchAck) begin
                        fetchReq <= 1'b0;
                    end else if (!fetchReq && !fetchAck) begin
                        if (fetchColumn == lastColumn) begin
                            bufferRow[fillBuffer] <= fillRow;
                            bufferValid[fillBuffer] <= 1'b1;
                            olderBuffer <= !fillBuffer;
                            state <= cacheFetch;
                        end else begin
                            fetchColumn <= fetchColumn + 1'b1;
                            fetchReq <= 1'b1;
                        end
                    end
                end
                cacheReadout: begin
                    if (advance) begin
                        readColumn <= readColumn + 1'b1;
                        if (readColumn == lastColumn) begin
                            state <= cacheIdle;
                        end
                    end
                end
                default: begin
                    state <= cacheIdle;
                end
            endcase
        end
    end

    always_ff @(posedge scalerClock) begin
        if (jobTaken) begin
            currentJob <= rowJob;
        end
        if (state == cacheFetch) begin
            fillBuffer <= victimBuffer;
            fillRow <= upperHeld ? currentJob.lowerRow : currentJob.upperRow;
        end
    end

    always_ff @(posedge scalerClock) begin
        if (captureStrobe) begin
            lineBuffer[fillBuffer][fetchColumn] <= fetchPixel;
        end
    end

    // Read-out stage of the blend pipeline that freezes while the output is stalled
    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            blendValid <= 1'b0;
        end else if (advance) begin
            blendValid <= (state == cacheReadout);
        end
    end

    always_ff @(posedge scalerClock) begin
        if (advance && (state == cacheReadout)) begin
            blendJob.upperPixel <= lineBuffer[upperBuffer][readColumn];
            blendJob.lowerPixel <= lineBuffer[lowerBuffer][readColumn];
            blendJob.fraction <= currentJob.fraction;
        end
    end

    fetchAddrStable: assert property (
        @(posedge scalerClock) disable iff (reset)
        fetchReq && $past(fetchReq) |-> $stable(fetchAddr)
    ) else $error("fetchAddr changed while fetchReq was high");

endmodule

// File: source/pixelBlender.sv
/*
 * Pixel blender
 * Three-stage pipeline that weights the upper and lower pixels by their
 * coefficients, sums each color component and tags the result with its
 * column. The last stage drives the output handshake.
 */
`timescale 1ns/10ps

module pixelBlender #(
    parameter int lineColumns = 16
) (
    input  logic scalerClock,
    input  logic reset,
    input  logic blendValid,
    input  pixelPkg::blendJobT blendJob,
    output logic advance,
    output logic outReq,
    output pixelPkg::outBeatT outBeat,
    input  logic outAck
);
    import scalerGeometryPkg::*;
    import pixelPkg::*;

    localparam int columnBits = $clog2(lineColumns);
    localparam logic [columnBits-1:0] lastColumn = columnBits'(lineColumns - 1);
    localparam int weightBits = $bits(greenT) + $bits(scaleT);

    typedef logic [weightBits-1:0] weightT;

    typedef struct packed {
        weightT red;
        weightT green;
        weightT blue;
    } weightSetT;

    logic coeffValid;
    logic weightValid;
    logic beatValid;
    rgbPixelT coeffUpper;
    rgbPixelT coeffLower;
    scaleT upperCoeff;
    scaleT lowerCoeff;
    weightSetT upperWeight;
    weightSetT lowerWeight;
    weightT sumRed;
    weightT sumGreen;
    weightT sumBlue;
    rgbPixelT blended;
    logic [columnBits-1:0] column;

    // The output register is free or is being handed off this cycle
    assign advance = !beatValid || (outReq && outAck);

    always_ff @(posedge scalerClock) begin
        if (advance) begin
            coeffUpper <= blendJob.upperPixel;
            coeffLower <= blendJob.lowerPixel;
            if (blendJob.fraction == '0) begin
                // Full weight on the upper row
                upperCoeff <= {1'b1, {fractionBits{1'b0}}};
                lowerCoeff <= '0;
            end else begin
                upperCoeff <= {1'b0, ~blendJob.fraction};
                lowerCoeff <= {1'b0, blendJob.fraction};
            end

            upperWeight.red <= weightT'(coeffUpper.red) * weightT'(upperCoeff);
            upperWeight.green <= weightT'(coeffUpper.green) * weightT'(upperCoeff);
            upperWeight.blue <= weightT'(coeffUpper.blue) * weightT'(upperCoeff);
            lowerWeight.red <= weightT'(coeffLower.red) * weightT'(lowerCoeff);
            lowerWeight.green <= weightT'(coeffLower.green) * weightT'(lowerCoeff);
            lowerWeight.blue <= weightT'(coeffLower.blue) * weightT'(lowerCoeff);

            if (weightValid) begin
                outBeat.pixel <= blended;
                outBeat.column <= columnIndexT'(column);
            end
        end
    end

    // Coefficients never sum past 64, so each component fits after the shift
    assign sumRed = upperWeight.red + lowerWeight.red;
    assign sumGreen = upperWeight.green + lowerWeight.green;
    assign sumBlue = upperWeight.blue + lowerWeight.blue;
    assign blended.red = redT'(sumRed >> fractionBits);
    assign blended.green = greenT'(sumGreen >> fractionBits);
    assign blended.blue = blueT'(sumBlue >> fractionBits);

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            coeffValid <= 1'b0;
            weightValid <= 1'b0;
            beatValid <= 1'b0;
            outReq <= 1'b0;
            column <= '0;
        end else begin
            if (advance) begin
                coeffValid <= blendValid;
                weightValid <= coeffValid;
                beatValid <= weightValid;
                if (weightValid) begin
                    column <= (column == lastColumn) ? '0 : column + 1'b1;
                end
            end
            // Next beat is offered only once the client has released outAck
            if (outReq && outAck) begin
                outReq <= 1'b0;
            end else if (beatValid && !outReq && !outAck) begin
                outReq <= 1'b1;
            end
        end
    end

    outBeatStable: assert property (
        @(posedge scalerClock) disable iff (reset)
        outReq && $past(outReq) |-> $stable(outBeat)
    ) else $error("outBeat changed while outReq was high");

endmodule

// File: source/verticalStretch.sv
/*
 * Vertical stretch top level
 * Scales frame height by linear interpolation between two upstream rows.
 * Connects the row mapper, the line cache and the pixel blender.
 */
`timescale 1ns/10ps

module verticalStretch #(
    parameter int lineColumns = 16
) (
    input  logic scalerClock,
    input  logic reset,
    input  scalerGeometryPkg::scaleT shrinkFactor,
    input  logic rowReq,
    input  scalerGeometryPkg::rowIndexT requestRow,
    output logic rowAck,
    output logic fetchReq,
    output scalerGeometryPkg::fetchAddrT fetchAddr,
    input  logic fetchAck,
    input  pixelPkg::rgbPixelT fetchPixel,
    output logic outReq,
    output pixelPkg::outBeatT outBeat,
    input  logic outAck
);
    logic jobValid;
    logic jobTaken;
    scalerGeometryPkg::rowJobT rowJob;
    logic blendValid;
    logic advance;
    pixelPkg::blendJobT blendJob;

    rowMapper mapper (
        .scalerClock(scalerClock),
        .reset(reset),
        .shrinkFactor(shrinkFactor),
        .rowReq(rowReq),
        .requestRow(requestRow),
        .rowAck(rowAck),
        .jobValid(jobValid),
        .rowJob(rowJob),
        .jobTaken(jobTaken)
    );

    lineCache #(.lineColumns(lineColumns)) cache (
        .scalerClock(scalerClock),
        .reset(reset),
        .jobValid(jobValid),
        .rowJob(rowJob),
        .jobTaken(jobTaken),
        .fetchReq(fetchReq),
        .fetchAddr(fetchAddr),
        .fetchAck(fetchAck),
        .fetchPixel(fetchPixel),
        .advance(advance),
        .blendValid(blendValid),
        .blendJob(blendJob)
    );

    pixelBlender #(.lineColumns(lineColumns)) blender (
        .scalerClock(scalerClock),
        .reset(reset),
        .blendValid(blendValid),
        .blendJob(blendJob),
        .advance(advance),
        .outReq(outReq),
        .outBeat(outBeat),
        .outAck(outAck)
    );

endmodule

// File: dv/verticalStretchTb.sv
/*
 * Vertical stretch testbench
 * Requests rows from a stimulus table, answers fetches with hashed source
 * pixels and checks every output beat against the row mapping and blend
 * rules. Some rows add random delays on both acknowledges.
 */
`timescale 1ns/10ps

module verticalStretchTb;
    import scalerGeometryPkg::*;
    import pixelPkg::*;

    localparam int lineColumns = 16;
    localparam int columnBits = $clog2(lineColumns);
    localparam int stimulusCount = 14;
    localparam int ackTimeout = 50;
    localparam int rowTimeout = 3000;
    localparam logic [31:0] randomSeed = 32'heeb778dc;

    typedef struct packed {
        scaleT shrink;
        rowIndexT row;
        logic [1:0] fetchRows;
        logic slow;
    } stimulusT;

    logic scalerClock = 1'b0;
    logic reset;
    scaleT shrinkFactor;
    logic rowReq;
    rowIndexT requestRow;
    logic rowAck;
    logic fetchReq;
    fetchAddrT fetchAddr;
    logic fetchAck = 1'b0;
    rgbPixelT fetchPixel = '0;
    logic outReq;
    outBeatT outBeat;
    logic outAck = 1'b0;

    stimulusT stimulus [stimulusCount];

    // Expected mapping of the row in flight
    int expUpper;
    int expLower;
    int expFraction;
    bit slowMode;

    // Model of the two buffer tags
    int tagRow [2];
    bit tagValid [2];
    bit olderTag;

    int missingRow [2];
    int missingCount;
    int fetchCount [2];
    logic [lineColumns-1:0] columnSeen [2];
    int beatCount;

    int fetchWait = 0;
    int outWait = 0;
    logic [31:0] fetchDelayState = randomSeed;
    logic [31:0] outDelayState = randomSeed;
    int fetchErrors = 0;
    int beatErrors = 0;
    int rowErrors = 0;
    int timeouts = 0;

    always #10 scalerClock = ~scalerClock;

    verticalStretch #(.lineColumns(lineColumns)) DUT (
        .scalerClock(scalerClock),
        .reset(reset),
        .shrinkFactor(shrinkFactor),
        .rowReq(rowReq),
        .requestRow(requestRow),
        .rowAck(rowAck),
        .fetchReq(fetchReq),
        .fetchAddr(fetchAddr),
        .fetchAck(fetchAck),
        .fetchPixel(fetchPixel),
        .outReq(outReq),
        .outBeat(outBeat),
        .outAck(outAck)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] mixed;
        mixed = value ^ (value << 13);
        mixed = mixed ^ (mixed >> 17);
        mixed = mixed ^ (mixed << 5);
        return mixed;
    endfunction

    // Upstream pixel at a row and column as a hash of both
    function automatic rgbPixelT sourcePixel(input rowIndexT row, input columnIndexT column);
        logic [31:0] hash;
        hash = randomSeed ^ {5'b0, row, 5'b0, column};
        hash = xorshift32(hash);
        hash = xorshift32(hash);
        return rgbPixelT'(hash[15:0]);
    endfunction

    function automatic int blendComponent(input int upperValue, input int lowerValue,
                                          input int fraction);
        return (upperValue * (63 - fraction) + lowerValue * fraction) >> 6;
    endfunction

    function automatic rgbPixelT blendPixels(input rgbPixelT upper, input rgbPixelT lower,
                                             input int fraction);
        rgbPixelT result;
        result = upper;
        if (fraction != 0) begin
            result.red = redT'(blendComponent(int'(upper.red), int'(lower.red), fraction));
            result.green = greenT'(blendComponent(int'(upper.green), int'(lower.green), fraction));
            result.blue = blueT'(blendComponent(int'(upper.blue), int'(lower.blue), fraction));
        end
        return result;
    endfunction

    function automatic bit tagNeeded(input bit index);
        return tagValid[index] && (tagRow[index] == expUpper || tagRow[index] == expLower);
    endfunction

    task automatic reportMismatch(input string signalName, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAIL time=%0t %s expected=0x%0h actual=0x%0h", $time, signalName,
                 expected, actual);
    endtask

    task automatic noteFetch(input rowIndexT row, input columnIndexT column);
        bit found;
        bit slot;
        found = 1'b0;
        slot = 1'b0;
        for (int s = 0; s < 2; s++) begin
            if (!found && s < missingCount && int'(row) == missingRow[s]) begin
                found = 1'b1;
                slot = s[0];
            end
        end
        if (!found) begin
            fetchErrors++;
            $display("ERROR: unexpected fetch of upstream row %0d at %0t", row, $time);
        end else if (int'(column) >= lineColumns) begin
            fetchErrors++;
            $display("ERROR: fetch of column %0d past the end of a row at %0t", column, $time);
        end else if (columnSeen[slot][column[columnBits-1:0]]) begin
            fetchErrors++;
            $display("ERROR: repeated fetch of row %0d column %0d at %0t", row, column, $time);
        end else begin
            columnSeen[slot][column[columnBits-1:0]] = 1'b1;
            fetchCount[slot] = fetchCount[slot] + 1;
        end
    endtask

    task automatic checkBeat();
        rgbPixelT expected;
        if (beatCount >= lineColumns) begin
            beatErrors++;
            $display("ERROR: extra output beat for column %0d at %0t", outBeat.column, $time);
        end else begin
            expected = blendPixels(sourcePixel(rowIndexT'(expUpper), columnIndexT'(beatCount)),
                                   sourcePixel(rowIndexT'(expLower), columnIndexT'(beatCount)),
                                   expFraction);
            if (outBeat.column != columnIndexT'(beatCount)) begin
                beatErrors++;
                reportMismatch("outBeat.column", 32'(beatCount), 32'(outBeat.column));
            end
            if (outBeat.pixel != expected) begin
                beatErrors++;
                reportMismatch("outBeat.pixel", 32'(expected), 32'(outBeat.pixel));
            end
        end
        beatCount = beatCount + 1;
    endtask

    // Upstream source that answers one pixel per fetch handshake
    always @(negedge scalerClock) begin
        if (!reset) begin
            if (fetchReq && !fetchAck) begin
                if (fetchWait > 0) begin
                    fetchWait <= fetchWait - 1;
                end else begin
                    noteFetch(fetchAddr.row, fetchAddr.column);
                    fetchPixel <= sourcePixel(fetchAddr.row, fetchAddr.column);
                    fetchAck <= 1'b1;
                    fetchDelayState = xorshift32(fetchDelayState);
                    fetchWait <= slowMode ? int'(fetchDelayState[1:0]) : 0;
                end
            end else if (!fetchReq && fetchAck) begin
                fetchAck <= 1'b0;
            end
        end
    end

    // Downstream client that checks each beat as it acknowledges it
    always @(negedge scalerClock) begin
        if (!reset) begin
            if (outReq && !outAck) begin
                if (outWait > 0) begin
                    outWait <= outWait - 1;
                end else begin
                    checkBeat();
                    outAck <= 1'b1;
                    outDelayState = xorshift32(outDelayState);
                    outWait <= slowMode ? int'(outDelayState[1:0]) : 0;
                end
            end else if (!outReq && outAck) begin
                outAck <= 1'b0;
            end
        end
    end

    // Works out the mapping and which rows the two buffers are missing
    task automatic planRow(input stimulusT entry);
        int sf;
        int coordinate;
        int neededRow;
        bit held;
        bit victim;
        sf = int'(entry.shrink);
        coordinate = int'(entry.row) * sf + sf / 2;
        if (sf >= 64) begin
            coordinate = coordinate - 32;
        end
        expUpper = coordinate / 64;
        expFraction = coordinate % 64;
        expLower = (expFraction != 0) ? expUpper + 1 : expUpper;
        missingCount = 0;
        for (int n = 0; n < 2; n++) begin
            if (n == 0 || expLower != expUpper) begin
                neededRow = (n == 0) ? expUpper : expLower;
                held = (tagValid[0] && tagRow[0] == neededRow) ||
                       (tagValid[1] && tagRow[1] == neededRow);
                if (!held) begin
                    victim = tagNeeded(olderTag) ? !olderTag : olderTag;
                    tagRow[victim] = neededRow;
                    tagValid[victim] = 1'b1;
                    olderTag = !victim;
                    missingRow[missingCount] = neededRow;
                    missingCount = missingCount + 1;
                end
            end
        end
        fetchCount[0] = 0;
        fetchCount[1] = 0;
        columnSeen[0] = '0;
        columnSeen[1] = '0;
        beatCount = 0;
        slowMode = entry.slow;
    endtask

    task automatic waitForRowAck(input logic level, output bit ok);
        int cycles;
        cycles = 0;
        while (rowAck !== level && cycles < ackTimeout) begin
            @(negedge scalerClock);
            cycles++;
        end
        ok = (rowAck === level);
        if (!ok) begin
            $display("ERROR: timeout at %0t waiting for rowAck to go %b", $time, level);
        end
    endtask

    task automatic waitForBeats(output bit ok);
        int cycles;
        cycles = 0;
        while (!(beatCount >= lineColumns && !outReq && !outAck) && cycles < rowTimeout) begin
            @(negedge scalerClock);
            cycles++;
        end
        ok = beatCount >= lineColumns && !outReq && !outAck;
        if (!ok) begin
            $display("ERROR: timeout at %0t with %0d of %0d beats delivered", $time,
                     beatCount, lineColumns);
        end
    endtask

    task automatic checkFetches(input stimulusT entry);
        int observedRows;
        observedRows = 0;
        for (int s = 0; s < 2; s++) begin
            if (fetchCount[s] > 0) begin
                observedRows++;
            end
        end
        if (observedRows != int'(entry.fetchRows)) begin
            rowErrors++;
            reportMismatch("fetchedRows", 32'(entry.fetchRows), 32'(observedRows));
        end
        for (int s = 0; s < 2; s++) begin
            if (s < missingCount && fetchCount[s] != lineColumns) begin
                rowErrors++;
                reportMismatch("fetchCount", lineColumns, fetchCount[s]);
            end
        end
    endtask

    task automatic applyRow(input stimulusT entry);
        bit ok;
        planRow(entry);
        shrinkFactor = entry.shrink;
        requestRow = entry.row;
        rowReq = 1'b1;
        waitForRowAck(1'b1, ok);
        if (ok) begin
            rowReq = 1'b0;
            waitForRowAck(1'b0, ok);
        end
        if (ok) begin
            waitForBeats(ok);
        end
        if (ok) begin
            checkFetches(entry);
        end else begin
            timeouts++;
        end
    endtask

    task automatic checkIdle();
        if (rowAck !== 1'b0) begin
            rowErrors++;
            reportMismatch("rowAck", 0, 32'(rowAck));
        end
        if (fetchReq !== 1'b0) begin
            rowErrors++;
            reportMismatch("fetchReq", 0, 32'(fetchReq));
        end
        if (outReq !== 1'b0) begin
            rowErrors++;
            reportMismatch("outReq", 0, 32'(outReq));
        end
    endtask

    initial begin
        reset = 1'b1;
        rowReq = 1'b0;
        requestRow = '0;
        shrinkFactor = 7'd64;
        tagValid[0] = 1'b0;
        tagValid[1] = 1'b0;
        tagRow[0] = 0;
        tagRow[1] = 0;
        olderTag = 1'b0;
        missingCount = 0;
        beatCount = 0;
        slowMode = 1'b0;

        // Shrink factor, downstream row, rows to fetch, random delays
        stimulus = '{
            '{7'd64, 11'd0, 2'd1, 1'b0},
            '{7'd64, 11'd1, 2'd1, 1'b0},
            '{7'd64, 11'd2, 2'd1, 1'b0},
            '{7'd64, 11'd2, 2'd0, 1'b0},
            '{7'd40, 11'd3, 2'd1, 1'b0},
            '{7'd40, 11'd4, 2'd0, 1'b0},
            '{7'd40, 11'd5, 2'd1, 1'b1},
            '{7'd40, 11'd6, 2'd1, 1'b1},
            '{7'd40, 11'd20, 2'd2, 1'b1},
            '{7'd100, 11'd0, 2'd2, 1'b0},
            '{7'd100, 11'd1, 2'd1, 1'b0},
            '{7'd100, 11'd7, 2'd2, 1'b1},
            '{7'd100, 11'd8, 2'd1, 1'b1},
            '{7'd127, 11'd10, 2'd2, 1'b0}
        };

        repeat (8) @(posedge scalerClock);
        @(negedge scalerClock);
        reset = 1'b0;
        repeat (5) begin
            @(negedge scalerClock);
            checkIdle();
        end

        for (int i = 0; i < stimulusCount && timeouts == 0; i++) begin
            applyRow(stimulus[i]);
        end

        // Any beat after the last row counts as an extra beat
        repeat (20) @(negedge scalerClock);

        $display("Errors: row %0d, fetch %0d, beat %0d, timeouts %0d", rowErrors,
                 fetchErrors, beatErrors, timeouts);
        if (rowErrors + fetchErrors + beatErrors + timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: src.f
source/scalerGeometryPkg.sv
source/pixelPkg.sv
source/rowMapper.sv
source/lineCache.sv
source/pixelBlender.sv
source/verticalStretch.sv
dv/verticalStretchTb.sv

// File: Makefile
# Verilator build and run of the vertical scaler testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, result taken from $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module verticalStretchTb -Mdir obj_dir
	./obj_dir/VverticalStretchTb | tee $(LOG)
	@if grep -q "Done: no errors" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
